// File: rtl/cell_renderer.sv
`timescale 1ns/1ns
`default_nettype none

module cell_renderer
    import screen_pkg::*, text_pkg::*;
#(
    parameter logic [COLOUR_W-1:0] INK_COLOUR = 3'b010
)
(
    input  logic                clk,
    input  logic                rst,
    input  logic                draw_start,
    input  char_code_t          draw_code,
    input  logic [COL_W-1:0]    col,
    input  logic [ROW_W-1:0]    row,
    output logic                plot,
    output logic [X_W-1:0]      x,
    output logic [Y_W-1:0]      y,
    output logic [COLOUR_W-1:0] colour,
    output logic                draw_done
);

    localparam logic [PIX_IDX_W-1:0] LAST_PIX = PIX_IDX_W'(CELL_W * CELL_H - 1);
    // Each glyph row covers two pixel rows
    localparam logic [3:0] GLYPH_ROW_END = 4'(2 * CELL_W - 1);

    logic                 active;
    logic [PIX_IDX_W-1:0] pix;
    logic [COL_W-1:0]     col_q;
    logic [ROW_W-1:0]     row_q;
    glyph_t               glyph_q;
    glyph_t               rom_glyph;
    logic                 pix_bit;

    glyph_rom i_glyph_rom (
        .code  (draw_code),
        .glyph (rom_glyph)
    );

    assign pix_bit   = glyph_q[63 - pix[2:0]];  // Current glyph row in top byte
    assign plot      = active;
    assign draw_done = active && (pix == LAST_PIX);
    assign x         = {col_q, pix[2:0]};
    assign y         = {row_q, pix[6:3]};
    assign colour    = pix_bit ? INK_COLOUR : '0;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            active <= 1'b0;
            pix    <= '0;
        end
        else if (draw_start)
        begin
            active <= 1'b1;
            pix    <= '0;
        end
        else if (active)
        begin
            if (draw_done)
                active <= 1'b0;
            pix <= pix + 1'b1;  // Wraps back to 0 after the last pixel
        end
    end

    always_ff @(posedge clk)
    begin
        if (draw_start)
        begin
            col_q   <= col;
            row_q   <= row;
            glyph_q <= rom_glyph;
        end
        else if (active && pix[3:0] == GLYPH_ROW_END)
            glyph_q <= glyph_q << CELL_W;
    end

    // FSM must wait for draw_done before the next cell
    a_no_restart: assert property (@(posedge clk) disable iff (rst)
        draw_start |-> !active)
        else $error("draw_start while a cell is in progress");

endmodule

`default_nettype wire

// File: rtl/cursor_tracker.sv
`timescale 1ns/1ns
`default_nettype none

module cursor_tracker
    import screen_pkg::*, text_pkg::*;
#(
    parameter int COLS = 40,
    parameter int ROWS = 15
)
(
    input  logic             clk,
    input  logic             rst,
    input  logic             cmd_valid,
    input  cursor_cmd_t      cmd,
    output logic [COL_W-1:0] col,
    output logic [ROW_W-1:0] row
);

    localparam logic [COL_W-1:0] LAST_COL = COL_W'(COLS - 1);
    localparam logic [ROW_W-1:0] LAST_ROW = ROW_W'(ROWS - 1);

    logic             at_top;
    logic             at_bottom;
    logic [ROW_W-1:0] row_up;
    logic [ROW_W-1:0] row_down;

    // Row clamps at the screen edges, no scrolling
    assign at_top    = (row == '0);
    assign at_bottom = (row == LAST_ROW);
    assign row_up    = at_top ? row : row - 1'b1;
    assign row_down  = at_bottom ? row : row + 1'b1;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            col <= '0;
            row <= '0;
        end
        else if (cmd_valid)
        begin
            case (cmd)
                CMD_UP:   row <= row_up;
                CMD_DOWN: row <= row_down;
                CMD_LEFT:
                begin
                    if (col == '0)
                    begin
                        col <= LAST_COL;  // End of previous line
                        row <= row_up;
                    end
                    else
                        col <= col - 1'b1;
                end
                CMD_RIGHT:
                begin
                    if (col == LAST_COL)
                    begin
                        col <= '0;
                        row <= row_down;
                    end
                    else
                        col <= col + 1'b1;
                end
                CMD_HOME: col <= '0;
                CMD_END:  col <= LAST_COL;
                CMD_NEWLINE:
                begin
                    col <= '0;
                    row <= row_down;
                end
                default: ;
            endcase
        end
    end

    a_col_range: assert property (@(posedge clk) disable iff (rst) col < COLS)
        else $error("cursor column out of range");
    a_row_range: assert property (@(posedge clk) disable iff (rst) row < ROWS)
        else $error("cursor row out of range");

endmodule

`default_nettype wire

// File: rtl/editor_fsm.sv
`timescale 1ns/1ns
`default_nettype none

module editor_fsm
    import text_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        char_valid,
    input  char_code_t  char_code,
    output logic        busy,
    output logic        draw_start,
    output char_code_t  draw_code,
    input  logic        draw_done,
    output logic        cmd_valid,
    output cursor_cmd_t cmd
);

    editor_state_t state;
    cursor_cmd_t   code_cmd;
    logic          code_mapped;
    logic          printable;
    logic          accept;

    assign accept    = char_valid && !busy;  // Strobes while busy are dropped
    assign printable = (char_code >= PRINT_FIRST) && (char_code <= PRINT_LAST);

    // Control code to cursor command
    always_comb
    begin
        code_mapped = 1'b1;
        code_cmd    = CMD_RIGHT;
        case (char_code)
            CODE_UP:    code_cmd = CMD_UP;
            CODE_DOWN:  code_cmd = CMD_DOWN;
            CODE_LEFT:  code_cmd = CMD_LEFT;
            CODE_RIGHT: code_cmd = CMD_RIGHT;
            CODE_HOME:  code_cmd = CMD_HOME;
            CODE_END:   code_cmd = CMD_END;
            CODE_ENTER: code_cmd = CMD_NEWLINE;
            default:    code_mapped = 1'b0;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state      <= S_IDLE;
            busy       <= 1'b0;
            draw_start <= 1'b0;
            cmd_valid  <= 1'b0;
        end
        else
        begin
            draw_start <= 1'b0;
            cmd_valid  <= 1'b0;
            case (state)
                S_IDLE:
                begin
                    busy <= accept;  // Unmapped codes still show one busy cycle
                    if (accept && printable)
                    begin
                        state      <= S_DRAW;
                        draw_start <= 1'b1;
                    end
                    else if (accept && code_mapped)
                    begin
                        state     <= S_MOVE;
                        cmd_valid <= 1'b1;
                    end
                end
                S_DRAW:
                begin
                    if (draw_done)
                    begin
                        state     <= S_MOVE;
                        cmd_valid <= 1'b1;  // Advance after the last pixel
                    end
                end
                S_MOVE:
                begin
                    busy  <= 1'b0;
                    state <= S_IDLE;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (state == S_IDLE && accept)
        begin
            draw_code <= char_code;
            if (printable)
                cmd <= CMD_RIGHT;
            else
                cmd <= code_cmd;
        end
    end

    a_excl: assert property (@(posedge clk) disable iff (rst) !(cmd_valid && draw_start))
        else $error("cursor move and cell draw started together");

endmodule

`default_nettype wire

// File: rtl/glyph_rom.sv
`timescale 1ns/1ns
`default_nettype none

module glyph_rom
    import screen_pkg::*, text_pkg::*;
(
    input  char_code_t code,
    output glyph_t     glyph
);

    // Hex digits only, everything else draws blank
    always_comb
    begin
        case (code)
            7'h30:   glyph = 64'h3C666E7666663C00;  // 0
            7'h31:   glyph = 64'h183818181818_7E00;
            7'h32:   glyph = 64'h3C66060C18307E00;
            7'h33:   glyph = 64'h3C66061C06663C00;
            7'h34:   glyph = 64'h0C1C3C6C7E0C0C00;
            7'h35:   glyph = 64'h7E607C0606663C00;
            7'h36:   glyph = 64'h3C607C6666663C00;
            7'h37:   glyph = 64'h7E060C1830303000;
            7'h38:   glyph = 64'h3C66663C66663C00;
            7'h39:   glyph = 64'h3C66663E060C3800;  // 9
            7'h41:   glyph = 64'h183C66667E666600;  // A
            7'h42:   glyph = 64'h7C66667C66667C00;
            7'h43:   glyph = 64'h3C66606060663C00;
            7'h44:   glyph = 64'h786C6666666C7800;
            7'h45:   glyph = 64'h7E60607C60607E00;
            7'h46:   glyph = 64'h7E60607C60606000;  // F
            default: glyph = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/screen_pkg.sv
`default_nettype none

package screen_pkg;

    // Cell geometry in pixels
    localparam int CELL_W    = 8;
    localparam int CELL_H    = 16;
    localparam int PIX_IDX_W = 7;

    // Cursor position widths
    localparam int COL_W = 6;
    localparam int ROW_W = 4;

    localparam int X_W      = 9;  // 320 wide
    localparam int Y_W      = 8;  // 240 high
    localparam int COLOUR_W = 3;

    // Row 0 in the top byte, leftmost pixel in each byte's MSB
    typedef logic [63:0] glyph_t;

endpackage

`default_nettype wire

// File: rtl/text_editor_top.sv
`timescale 1ns/1ns
`default_nettype none

module text_editor_top
    import screen_pkg::*, text_pkg::*;
#(
    parameter int                  COLS       = 40,
    parameter int                  ROWS       = 15,
    parameter logic [COLOUR_W-1:0] INK_COLOUR = 3'b010
)
(
    input  logic                clk,
    input  logic                rst,
    input  logic                char_valid,
    input  logic [6:0]          char_code,
    output logic                plot,
    output logic [X_W-1:0]      x,
    output logic [Y_W-1:0]      y,
    output logic [COLOUR_W-1:0] colour,
    output logic                busy,
    output logic [COL_W-1:0]    cursor_col,
    output logic [ROW_W-1:0]    cursor_row
);

    logic        draw_start;
    char_code_t  draw_code;
    logic        draw_done;
    logic        cmd_valid;
    cursor_cmd_t cmd;

    editor_fsm i_editor_fsm (
        .clk        (clk),
        .rst        (rst),
        .char_valid (char_valid),
        .char_code  (char_code_t'(char_code)),
        .busy       (busy),
        .draw_start (draw_start),
        .draw_code  (draw_code),
        .draw_done  (draw_done),
        .cmd_valid  (cmd_valid),
        .cmd        (cmd)
    );

    cell_renderer #(.INK_COLOUR(INK_COLOUR)) i_cell_renderer (
        .clk        (clk),
        .rst        (rst),
        .draw_start (draw_start),
        .draw_code  (draw_code),
        .col        (cursor_col),
        .row        (cursor_row),
        .plot       (plot),
        .x          (x),
        .y          (y),
        .colour     (colour),
        .draw_done  (draw_done)
    );

    cursor_tracker #(.COLS(COLS), .ROWS(ROWS)) i_cursor_tracker (
        .clk       (clk),
        .rst       (rst),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .col       (cursor_col),
        .row       (cursor_row)
    );

endmodule

`default_nettype wire

// File: rtl/text_pkg.sv
`default_nettype none

package text_pkg;

    // Control codes understood by the editor
    typedef enum logic [6:0] {
        CODE_ENTER = 7'h0A,
        CODE_HOME  = 7'h0D,
        CODE_UP    = 7'h11,
        CODE_LEFT  = 7'h12,
        CODE_DOWN  = 7'h13,
        CODE_RIGHT = 7'h14,
        CODE_END   = 7'h17
    } char_code_t;

    localparam logic [6:0] PRINT_FIRST = 7'h20;
    localparam logic [6:0] PRINT_LAST  = 7'h7E;

    typedef enum logic [2:0] {
        CMD_UP,
        CMD_DOWN,
        CMD_LEFT,
        CMD_RIGHT,
        CMD_HOME,
        CMD_END,
        CMD_NEWLINE
    } cursor_cmd_t;

    typedef enum logic [1:0] {
        S_IDLE,
        S_DRAW,
        S_MOVE
    } editor_state_t;

endpackage

`default_nettype wire

// File: testbench/tb_text_editor.sv
`timescale 1ns/1ns
`default_nettype none

module tb_text_editor;

    localparam int         CLK_PERIOD  = 20;
    localparam int         DRIVE_DELAY = 2;
    localparam int         RESET_CYCLES = 4;
    localparam logic [2:0] INK         = 3'b010;
    localparam             VEC_FILE    = "testbench/text_editor_vectors.txt";

    logic       clk = 1'b0;
    logic       rst;
    logic       char_valid;
    logic [6:0] char_code;
    logic       plot;
    logic [8:0] x;
    logic [7:0] y;
    logic [2:0] colour;
    logic       busy;
    logic [5:0] cursor_col;
    logic [3:0] cursor_row;

    int vec_code[$];
    int vec_col[$];
    int vec_row[$];
    int vec_plot[$];
    int vec_ink[$];

    int cycle_count = 0;
    int cycle_limit = 1000;  // Raised once the vectors are loaded
    int error_count = 0;
    int tests_failed = 0;
    int plot_count = 0;
    int ink_count = 0;
    int cell_col = 0;
    int cell_row = 0;

    text_editor_top i_dut (
        .clk        (clk),
        .rst        (rst),
        .char_valid (char_valid),
        .char_code  (char_code),
        .plot       (plot),
        .x          (x),
        .y          (y),
        .colour     (colour),
        .busy       (busy),
        .cursor_col (cursor_col),
        .cursor_row (cursor_row)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit)
        begin
            $display("Timeout after %0d cycles, busy never fell", cycle_count);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
    begin
        if (got !== expected)
        begin
            $display("MISMATCH %s: got 0x%0h, expected 0x%0h", name, got, expected);
            error_count = error_count + 1;
        end
    end
    endtask

    // Pixel order within the expected cursor cell
    always @(negedge clk)
    begin
        if (!rst && plot)
        begin
            check_value("x", x, cell_col * 8 + plot_count % 8);
            check_value("y", y, cell_row * 16 + plot_count / 8);
            if (colour == INK)
                ink_count = ink_count + 1;
            else
                check_value("colour", colour, 0);  // Background pixels
            plot_count = plot_count + 1;
        end
    end

    task automatic send_code(input logic [6:0] code);
    begin
        @(posedge clk);
        #DRIVE_DELAY;
        plot_count = 0;
        ink_count  = 0;
        char_code  = code;
        char_valid = 1'b1;
        @(posedge clk);
        #DRIVE_DELAY;
        check_value("busy", busy, 1);
        char_code = 7'h14;  // Stray RIGHT while busy
        @(posedge clk);
        #DRIVE_DELAY;
        char_valid = 1'b0;
        char_code  = '0;
    end
    endtask

    task automatic wait_idle();
    begin
        @(negedge clk);
        while (busy)
            @(negedge clk);
        #1;
    end
    endtask

    initial
    begin
        int               fd;
        int               n;
        int               fields;
        int               v_code;
        int               v_col;
        int               v_row;
        int               v_plot;
        int               v_ink;
        int               errs_before;
        logic [8*120-1:0] line;

        rst        = 1'b1;
        char_valid = 1'b0;
        char_code  = '0;

        fd = $fopen(VEC_FILE, "r");
        if (fd != 0)
        begin
            while (!$feof(fd))
            begin
                line = '0;
                n = $fgets(line, fd);
                if (n > 0)
                begin
                    fields = $sscanf(line, "%h %d %d %d %d", v_code, v_col, v_row,
                                     v_plot, v_ink);
                    if (fields == 5)  // Comment and blank lines fall through
                    begin
                        vec_code.push_back(v_code);
                        vec_col.push_back(v_col);
                        vec_row.push_back(v_row);
                        vec_plot.push_back(v_plot);
                        vec_ink.push_back(v_ink);
                    end
                end
            end
            $fclose(fd);
        end

        if (vec_code.size() == 0)
        begin
            $display("No vectors could be read from %s", VEC_FILE);
            $display("TESTBENCH FAILED");
            $finish;
        end
        else
        begin
            cycle_limit = vec_code.size() * 140 + 100;
            repeat (RESET_CYCLES) @(posedge clk);
            #DRIVE_DELAY;
            rst = 1'b0;

            @(negedge clk);
            errs_before = error_count;
            check_value("plot", plot, 0);
            check_value("busy", busy, 0);
            check_value("cursor_col", cursor_col, 0);
            check_value("cursor_row", cursor_row, 0);
            if (error_count == errs_before)
                $display("test 0 reset: pass");
            else
            begin
                $display("test 0 reset: fail");
                tests_failed = tests_failed + 1;
            end

            for (int i = 0; i < vec_code.size(); i++)
            begin
                errs_before = error_count;
                // Cell origin is where the previous step left the cursor
                cell_col = (i == 0) ? 0 : vec_col[i - 1];
                cell_row = (i == 0) ? 0 : vec_row[i - 1];
                send_code(vec_code[i]);
                wait_idle();
                check_value("cursor_col", cursor_col, vec_col[i]);
                check_value("cursor_row", cursor_row, vec_row[i]);
                check_value("plot_count", plot_count, vec_plot[i]);
                check_value("ink_count", ink_count, vec_ink[i]);
                if (error_count == errs_before)
                    $display("test %0d code 0x%02h: pass", i + 1, vec_code[i]);
                else
                begin
                    $display("test %0d code 0x%02h: fail", i + 1, vec_code[i]);
                    tests_failed = tests_failed + 1;
                end
            end

            $display("tests run %0d, failed %0d, mismatches %0d",
                     vec_code.size() + 1, tests_failed, error_count);
            if (error_count == 0)
                $display("TESTBENCH PASSED");
            else
                $display("TESTBENCH FAILED");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: testbench/text_editor_vectors.txt
# code(hex) col row plots ink, all after the step; a stray RIGHT
# strobe follows every code while busy and must be dropped
12 39 0 0 0
31 0 1 128 38
41 1 1 128 56
20 2 1 128 0
7a 3 1 128 0
11 3 0 0 0
11 3 0 0 0
17 39 0 0 0
14 0 1 0 0
12 39 0 0 0
0d 0 0 0 0
01 0 0 0 0
7f 0 0 0 0
13 0 1 0 0
0a 0 2 0 0
13 0 3 0 0
0a 0 4 0 0
13 0 5 0 0
13 0 6 0 0
13 0 7 0 0
13 0 8 0 0
13 0 9 0 0
13 0 10 0 0
13 0 11 0 0
13 0 12 0 0
13 0 13 0 0
13 0 14 0 0
13 0 14 0 0
17 39 14 0 0
0a 0 14 0 0
17 39 14 0 0
46 0 14 128 42
30 1 14 128 60
38 2 14 128 56

// File: text_editor.f
rtl/screen_pkg.sv
rtl/text_pkg.sv
rtl/glyph_rom.sv
rtl/cell_renderer.sv
rtl/cursor_tracker.sv
rtl/editor_fsm.sv
rtl/text_editor_top.sv
testbench/tb_text_editor.sv
